//--- Makefile
SIM := obj_dir/Vtb_cart_main

.PHONY: run clean

$(SIM): flist.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --top-module tb_cart_main -f flist.f -o Vtb_cart_main

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
source/snes_pkg.sv
source/rom_pkg.sv
source/snes_bus_sync.sv
source/snes_liveness.sv
source/rom_arbiter.sv
source/rom_bus_mux.sv
source/cart_main.sv
testbench/tb_cart_main.sv

//--- source/cart_main.sv
`default_nettype none

module cart_main import snes_pkg::*, rom_pkg::*; #(
  parameter int ROM_CYCLE_LEN = 7,
  parameter int DEAD_TIMEOUT = 86000,
  parameter logic [rom_addr_w-1:0] ROM_MASK = '1
) (
  input  wire                    CLK2,
  input  wire                    rst,
  // Console bus
  input  wire  [snes_addr_w-1:0] snes_addr,
  input  wire  [snes_data_w-1:0] snes_data_in,
  input  wire                    snes_rd_n,
  input  wire                    snes_wr_n,
  input  wire                    snes_cpu_clk,
  output logic [snes_data_w-1:0] snes_dout,
  output logic                   snes_doe,
  output logic                   snes_databus_dir,
  output logic                   snes_reset_strobe,
  // Microcontroller
  input  wire                    mcu_valid,
  input  wire                    mcu_write,
  input  wire  [rom_addr_w-1:0]  mcu_addr,
  input  wire  [7:0]             mcu_wdata,
  output logic                   mcu_ready,
  output logic [7:0]             mcu_rdata,
  // ROM
  output logic [rom_addr_w-2:0]  rom_addr,
  input  wire  [15:0]            rom_din,
  output logic [15:0]            rom_dout,
  output logic                   rom_doe,
  output logic                   rom_we_n,
  output logic                   rom_bhe_n,
  output logic                   rom_ble_n,
  output logic                   rom_oe_n,
  output logic                   rom_ce_n
);

  logic [snes_addr_w-1:0] snes_addr_f;
  logic snes_rd_n_f;
  logic cpu_clk_s1;
  logic cycle_start;
  logic cycle_end;
  logic snes_dead;
  logic rom_hit;
  acc_state_t acc_state;
  logic [rom_addr_w-1:0] acc_addr;

  // WE overrides OE on writes
  assign rom_oe_n = 1'b0;
  assign rom_ce_n = 1'b0;

  snes_bus_sync u_sync (
    .CLK2(CLK2), .snes_addr(snes_addr), .snes_data_in(snes_data_in),
    .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n), .snes_cpu_clk(snes_cpu_clk),
    .snes_addr_f(snes_addr_f), .snes_rd_n_f(snes_rd_n_f), .snes_wr_n_f(),
    .snes_cpu_clk_f(), .cpu_clk_s1(cpu_clk_s1),
    .cycle_start(cycle_start), .cycle_end(cycle_end)
  );

  snes_liveness #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_live (
    .CLK2(CLK2), .rst(rst), .cpu_clk_s1(cpu_clk_s1),
    .snes_dead(snes_dead), .snes_reset_strobe(snes_reset_strobe)
  );

  rom_arbiter #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_arb (
    .CLK2(CLK2), .rst(rst), .mcu_valid(mcu_valid), .mcu_write(mcu_write),
    .mcu_addr(mcu_addr), .cycle_start(cycle_start), .cycle_end(cycle_end),
    .rom_hit(rom_hit), .snes_dead(snes_dead), .cpu_clk_s1(cpu_clk_s1),
    .rom_din(rom_din), .mcu_ready(mcu_ready), .mcu_rdata(mcu_rdata),
    .acc_state(acc_state), .acc_addr(acc_addr)
  );

  rom_bus_mux #(.ROM_MASK(ROM_MASK)) u_mux (
    .snes_addr_f(snes_addr_f), .snes_rd_n_f(snes_rd_n_f), .acc_state(acc_state),
    .acc_addr(acc_addr), .mcu_wdata(mcu_wdata), .rom_din(rom_din),
    .rom_hit(rom_hit), .rom_addr(rom_addr), .rom_bhe_n(rom_bhe_n),
    .rom_ble_n(rom_ble_n), .rom_dout(rom_dout), .rom_doe(rom_doe),
    .rom_we_n(rom_we_n), .snes_dout(snes_dout), .snes_doe(snes_doe),
    .snes_databus_dir(snes_databus_dir)
  );

endmodule

`default_nettype wire

//--- source/rom_arbiter.sv
`default_nettype none

module rom_arbiter import rom_pkg::*; #(
  parameter int ROM_CYCLE_LEN = 7
) (
  input  wire                   CLK2,
  input  wire                   rst,
  input  wire                   mcu_valid,
  input  wire                   mcu_write,
  input  wire  [rom_addr_w-1:0] mcu_addr,
  input  wire                   cycle_start,
  input  wire                   cycle_end,
  input  wire                   rom_hit,
  input  wire                   snes_dead,
  input  wire                   cpu_clk_s1,
  input  wire  rom_word_t       rom_din,
  output logic                  mcu_ready,
  output logic [7:0]            mcu_rdata,
  output acc_state_t            acc_state,
  output logic [rom_addr_w-1:0] acc_addr
);

  logic rd_pend;
  logic wr_pend;
  logic free_strobe;
  logic accept;
  logic free_slot;
  logic restart;
  logic acc_done;
  cycle_cnt_t delay_cnt;

  assign accept = mcu_valid & mcu_ready;
  assign free_slot = cycle_end | free_strobe | snes_dead;
  assign restart = snes_dead & cpu_clk_s1;  // Console waking up mid access
  assign acc_done = (acc_state == st_rd_end) || (acc_state == st_wr_end);

  // Console cycle that does not touch ROM leaves the bus to us
  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  ////////////////////
  // Request handshake
  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_ready <= 1'b1;
    end else if (accept) begin
      rd_pend <= ~mcu_write;
      wr_pend <= mcu_write;
      mcu_ready <= 1'b0;
    end else if (acc_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_ready <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) acc_addr <= mcu_addr;
  end

  ////////////////////
  // Access FSM
  always_ff @(posedge CLK2) begin
    if (rst || restart) begin
      acc_state <= st_idle;
    end else begin
      case (acc_state)
        st_idle: begin
          delay_cnt <= cycle_cnt_t'(ROM_CYCLE_LEN);
          if (free_slot && rd_pend) acc_state <= st_rd_addr;
          else if (free_slot && wr_pend) acc_state <= st_wr_addr;
        end
        st_rd_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          mcu_rdata <= acc_addr[0] ? rom_din.lane[0] : rom_din.lane[1];
          if (delay_cnt == '0) acc_state <= st_rd_end;
        end
        st_wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) acc_state <= st_wr_end;
        end
        default: acc_state <= st_idle;  // Both end states
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/rom_bus_mux.sv
`default_nettype none

module rom_bus_mux import snes_pkg::*, rom_pkg::*; #(
  parameter logic [rom_addr_w-1:0] ROM_MASK = '1
) (
  input  wire  [snes_addr_w-1:0] snes_addr_f,
  input  wire                    snes_rd_n_f,
  input  wire  acc_state_t       acc_state,
  input  wire  [rom_addr_w-1:0]  acc_addr,
  input  wire  [7:0]             mcu_wdata,
  input  wire  rom_word_t        rom_din,
  output logic                   rom_hit,
  output logic [rom_addr_w-2:0]  rom_addr,
  output logic                   rom_bhe_n,
  output logic                   rom_ble_n,
  output rom_word_t              rom_dout,
  output logic                   rom_doe,
  output logic                   rom_we_n,
  output logic [snes_data_w-1:0] snes_dout,
  output logic                   snes_doe,
  output logic                   snes_databus_dir
);

  logic [rom_addr_w-1:0] mapped_addr;
  logic [rom_addr_w-1:0] sel_addr;
  logic mcu_hit;
  logic wr_hit;

  ////////////////////
  // Address decode
  assign rom_hit = snes_addr_f[15];  // Upper half of every bank
  assign mapped_addr = {1'b0, snes_addr_f[23:16], snes_addr_f[14:0]} & ROM_MASK;

  assign wr_hit = (acc_state == st_wr_addr);
  assign mcu_hit = wr_hit || (acc_state == st_rd_addr);
  assign sel_addr = mcu_hit ? acc_addr : mapped_addr;

  assign rom_addr = sel_addr[rom_addr_w-1:1];
  assign rom_bhe_n = sel_addr[0];  // Even byte on the high lane
  assign rom_ble_n = ~sel_addr[0];

  ////////////////////
  // Write path, byte goes to the enabled lane only
  assign rom_dout.lane[1] = sel_addr[0] ? 8'h00 : mcu_wdata;
  assign rom_dout.lane[0] = sel_addr[0] ? mcu_wdata : 8'h00;
  assign rom_doe = wr_hit;
  assign rom_we_n = ~wr_hit;

  // Console read return
  assign snes_dout = sel_addr[0] ? rom_din.lane[0] : rom_din.lane[1];
  assign snes_doe = ~snes_rd_n_f & rom_hit;
  assign snes_databus_dir = ~snes_rd_n_f;  // Toward the console

endmodule

`default_nettype wire

//--- source/rom_pkg.sv
`default_nettype none

package rom_pkg;

  localparam int rom_addr_w = 24;  // Byte address, word address is one bit less

  typedef logic [3:0] cycle_cnt_t;

  // One ROM word, seen whole on the bus side or split into byte lanes
  // Lane 1 is the high byte, lane 0 the low byte
  typedef union packed {
    logic [15:0] word;
    logic [1:0][7:0] lane;
  } rom_word_t;

  // One-hot access states
  typedef enum logic [4:0] {
    st_idle = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end = 5'b10000
  } acc_state_t;

endpackage

`default_nettype wire

//--- source/snes_bus_sync.sv
`default_nettype none

module snes_bus_sync import snes_pkg::*; (
  input  wire                    CLK2,
  input  wire  [snes_addr_w-1:0] snes_addr,
  input  wire  [snes_data_w-1:0] snes_data_in,
  input  wire                    snes_rd_n,
  input  wire                    snes_wr_n,
  input  wire                    snes_cpu_clk,
  output logic [snes_addr_w-1:0] snes_addr_f,
  output logic                   snes_rd_n_f,
  output logic                   snes_wr_n_f,
  output logic                   snes_cpu_clk_f,
  output logic                   cpu_clk_s1,
  output logic                   cycle_start,
  output logic                   cycle_end
);

  logic [sync_depth-1:0] rd_sr;
  logic [sync_depth-1:0] wr_sr;
  logic [sync_depth-1:0] clk_sr;
  logic [snes_addr_w-1:0] addr_sr [addr_delay];
  logic [3:0] clk_taps;

  ////////////////////
  // Input sampling
  always_ff @(posedge CLK2) begin
    rd_sr <= {rd_sr[sync_depth-2:0], snes_rd_n};
    wr_sr <= {wr_sr[sync_depth-2:0], snes_wr_n};
    clk_sr <= {clk_sr[sync_depth-2:0], snes_cpu_clk};
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < addr_delay; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // Levels from two adjacent taps
  assign snes_rd_n_f = rd_sr[2] & rd_sr[1];
  assign snes_wr_n_f = wr_sr[2] & wr_sr[1];
  assign snes_cpu_clk_f = clk_sr[2] & clk_sr[1];
  assign cpu_clk_s1 = clk_sr[1];  // Raw, for liveness

  // Address lags the strobes so it is stable when they fire
  assign snes_addr_f = addr_sr[addr_delay-1] & addr_sr[addr_delay-2];

  ////////////////////
  // Edge strobes
  assign clk_taps = clk_sr[4:1] & clk_sr[5:2];
  assign cycle_start = (clk_taps == cyc_start_pat);
  assign cycle_end = (clk_taps == cyc_end_pat);

endmodule

`default_nettype wire

//--- source/snes_liveness.sv
`default_nettype none

module snes_liveness #(
  parameter int DEAD_TIMEOUT = 86000
) (
  input  wire  CLK2,
  input  wire  rst,
  input  wire  cpu_clk_s1,
  output logic snes_dead,
  output logic snes_reset_strobe
);

  localparam int cnt_w = $clog2(DEAD_TIMEOUT + 1);

  logic [cnt_w-1:0] dead_cnt;

  // Low time of the console clock, saturating
  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt <= '0;
    end else if (cpu_clk_s1) begin
      dead_cnt <= '0;
    end else if (dead_cnt != cnt_w'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ////////////////////
  // Dead flag and wakeup strobe
  always_ff @(posedge CLK2) begin
    if (rst) begin
      snes_dead <= 1'b1;  // Assume no console until it clocks
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (cpu_clk_s1) begin
        snes_dead <= 1'b0;
        snes_reset_strobe <= snes_dead;  // Only when coming back to life
      end else if (dead_cnt == cnt_w'(DEAD_TIMEOUT)) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/snes_pkg.sv
`default_nettype none

package snes_pkg;

  ////////////////////
  // Console bus widths
  localparam int snes_addr_w = 24;
  localparam int snes_data_w = 8;

  ////////////////////
  // Sampling
  localparam int sync_depth = 8;  // Control input shift register
  localparam int addr_delay = 6;  // Address and data stages, last two ANDed

  // Edge detector tap patterns, oldest sample on the left
  localparam logic [5:0] rd_start_pat = 6'b111110;
  localparam logic [5:0] rd_end_pat = 6'b000001;
  localparam logic [5:0] wr_end_pat = 6'b000001;
  localparam logic [3:0] cyc_start_pat = 4'b0001;  // CPU clock rising
  localparam logic [3:0] cyc_end_pat = 4'b1110;    // CPU clock falling

endpackage

`default_nettype wire

//--- testbench/cart_vectors.mem
// One 48-bit word per line: kind (2 digits), byte address (6), data (2), expected (2)
// Kinds: 00 ROM byte, 01 console read, 02 MCU read, 03 MCU write,
// 04 MCU write with valid held, 05 console clock gap (address = cycles), ff end
000000103c00
000000117e00
00000020a100
00000021b200
00000041c400
01008010003c
01008011007e
0180802100b2
0200002000a1
030000315d00
02000031005d
01008031005d
04000040e700
0200004000e7
0200004100c4
050000080001
01008010003c
0200002000a1
030000509900
020000500099
050000100000
050001000001
01008011007e
ff0000000000

//--- testbench/tb_cart_main.sv
`default_nettype none

module tb_cart_main;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_vec = 64;
  localparam int cycles_per_vec = 400;

  logic CLK2 = 1'b0;
  logic rst = 1'b1;
  logic [23:0] snes_addr = '0;
  logic [7:0] snes_data_in = '0;
  logic snes_rd_n = 1'b1;
  logic snes_wr_n = 1'b1;
  logic snes_cpu_clk = 1'b0;
  logic mcu_valid = 1'b0;
  logic mcu_write = 1'b0;
  logic [23:0] mcu_addr = '0;
  logic [7:0] mcu_wdata = '0;

  logic [7:0] snes_dout;
  logic snes_doe;
  logic snes_databus_dir;
  logic snes_reset_strobe;
  logic mcu_ready;
  logic [7:0] mcu_rdata;
  logic [22:0] rom_addr;
  logic [15:0] rom_din;
  logic [15:0] rom_dout;
  logic rom_doe;
  logic rom_we_n;
  logic rom_bhe_n;
  logic rom_ble_n;
  logic rom_oe_n;
  logic rom_ce_n;

  logic [47:0] vec_mem [max_vec];  // kind, address, data, expected
  logic [15:0] rom_mem [256];
  int n_vec = 0;
  integer seed = 32'h64406836;
  int half_len;
  bit cons_run = 1'b0;
  bit cons_reading = 1'b0;
  logic [7:0] cons_exp;
  int we_pulses = 0;
  int strobes = 0;
  logic we_prev = 1'b1;

  always #10 CLK2 = ~CLK2;

  cart_main #(.DEAD_TIMEOUT(200)) dut (
    .CLK2(CLK2), .rst(rst), .snes_addr(snes_addr), .snes_data_in(snes_data_in),
    .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n), .snes_cpu_clk(snes_cpu_clk),
    .snes_dout(snes_dout), .snes_doe(snes_doe), .snes_databus_dir(snes_databus_dir),
    .snes_reset_strobe(snes_reset_strobe), .mcu_valid(mcu_valid), .mcu_write(mcu_write),
    .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata), .mcu_ready(mcu_ready),
    .mcu_rdata(mcu_rdata), .rom_addr(rom_addr), .rom_din(rom_din), .rom_dout(rom_dout),
    .rom_doe(rom_doe), .rom_we_n(rom_we_n), .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n),
    .rom_oe_n(rom_oe_n), .rom_ce_n(rom_ce_n)
  );

  ////////////////////
  // ROM model loaded during reset
  assign rom_din = rom_mem[rom_addr[7:0]];

  always @(posedge CLK2) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) rom_mem[i] <= {i[7:0] ^ 8'h5a, ~i[7:0]};
      for (int v = 0; v < n_vec; v++) begin
        if (vec_mem[v][47:40] == 8'h00) begin
          if (vec_mem[v][16]) rom_mem[vec_mem[v][24:17]][7:0] <= vec_mem[v][15:8];
          else rom_mem[vec_mem[v][24:17]][15:8] <= vec_mem[v][15:8];  // Even byte high
        end
      end
    end else if (rom_we_n === 1'b0) begin
      if (!rom_ble_n) rom_mem[rom_addr[7:0]][7:0] <= rom_dout[7:0];
      if (!rom_bhe_n) rom_mem[rom_addr[7:0]][15:8] <= rom_dout[15:8];
    end
  end

  // Console CPU clock with random half periods
  always begin
    @(posedge CLK2);
    if (cons_run) begin
      half_len = 4 + ($unsigned($random(seed)) % 8);
      snes_cpu_clk <= 1'b1;
      repeat (half_len) @(posedge CLK2);
      half_len = 4 + ($unsigned($random(seed)) % 8);
      snes_cpu_clk <= 1'b0;
      repeat (half_len) @(posedge CLK2);
    end
  end

  ////////////////////
  // Checks
  task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Write pulses, lane contents and wakeup strobes
  always @(negedge CLK2) begin
    if (!rst && we_prev && !rom_we_n) we_pulses++;
    if (!rst) begin
      // Data driven toward the ROM only during a write, chip always selected
      check_equal(16'({rom_doe, rom_oe_n, rom_ce_n}), 16'({~rom_we_n, 2'b00}),
                  "ROM drive and chip enables");
    end
    if (!rst && rom_we_n === 1'b0) begin
      check_equal(16'({rom_bhe_n, rom_ble_n}), 16'({mcu_addr[0], ~mcu_addr[0]}),
                  "byte lane enables");
      check_equal(16'(mcu_addr[0] ? rom_dout[7:0] : rom_dout[15:8]), 16'(mcu_wdata),
                  "byte on write lane");
    end
    we_prev = rom_we_n;
    if (snes_reset_strobe === 1'b1) strobes++;
  end

  ////////////////////
  // Vector operations
  task automatic console_read(input logic [23:0] addr, input logic [7:0] exp);
    @(posedge CLK2);
    snes_addr <= addr;
    snes_rd_n <= 1'b0;
    repeat (6) @(posedge CLK2);  // Address latency of the sampler
    @(negedge CLK2);
    check_equal(16'(snes_dout), 16'(exp), "console read data");
    check_equal(16'({snes_doe, snes_databus_dir}), 16'h3, "console drive enables");
    cons_exp = exp;
    cons_reading = 1'b1;
  endtask

  task automatic mcu_access(input logic wr, input logic [23:0] addr, input logic [7:0] data,
                            input logic [7:0] exp, input logic hold);
    int pulses_before;
    pulses_before = we_pulses;
    @(posedge CLK2);
    mcu_valid <= 1'b1;
    mcu_write <= wr;
    mcu_addr <= addr;
    mcu_wdata <= data;
    do @(negedge CLK2); while (mcu_ready !== 1'b1);
    @(posedge CLK2);  // Accepted on this edge
    if (!hold) mcu_valid <= 1'b0;
    @(negedge CLK2);
    check_equal(16'(mcu_ready), 16'h0, "mcu_ready after acceptance");
    if (hold) begin
      // Request stays up until the write has ended
      do @(negedge CLK2); while (rom_we_n !== 1'b0);
      while (rom_we_n !== 1'b1) @(negedge CLK2);
      @(posedge CLK2);  // Last edge of the end state, ready still low
      mcu_valid <= 1'b0;
      @(negedge CLK2);
    end
    while (mcu_ready !== 1'b1) @(negedge CLK2);
    if (wr) begin
      repeat (12) @(negedge CLK2);
      check_equal(16'(we_pulses - pulses_before), 16'h1, "ROM write pulses");
    end else begin
      check_equal(16'(mcu_rdata), 16'(exp), "mcu read data");
    end
    if (cons_run && cons_reading) begin
      check_equal(16'(snes_dout), 16'(cons_exp), "console read beside access");
    end
  endtask

  task automatic console_gap(input logic [23:0] gap, input logic [7:0] exp);
    int strobes_before;
    @(negedge CLK2);
    cons_run = 1'b0;  // Clock ends low after its current period
    strobes_before = strobes;
    repeat (gap) @(negedge CLK2);
    cons_run = 1'b1;
    repeat (40) @(negedge CLK2);
    check_equal(16'(strobes - strobes_before), 16'(exp), "reset strobe count");
  endtask

  ////////////////////
  // Main sequence
  initial begin : main_seq
    logic [7:0] kind;
    logic [23:0] addr;
    logic [7:0] data;
    logic [7:0] exp;
    $readmemh("testbench/cart_vectors.mem", vec_mem);
    while (n_vec < max_vec && vec_mem[n_vec][47:40] !== 8'hff) n_vec++;
    repeat (8) @(posedge CLK2);
    rst <= 1'b0;
    for (int v = 0; v < n_vec; v++) begin
      kind = vec_mem[v][47:40];
      addr = vec_mem[v][39:16];
      data = vec_mem[v][15:8];
      exp = vec_mem[v][7:0];
      case (kind)
        8'h00: ;  // ROM byte loaded in reset
        8'h01: console_read(addr, exp);
        8'h02: mcu_access(1'b0, addr, data, exp, 1'b0);
        8'h03: mcu_access(1'b1, addr, data, exp, 1'b0);
        8'h04: mcu_access(1'b1, addr, data, exp, 1'b1);
        8'h05: console_gap(addr, exp);
        default: abort_run("unknown operation kind in the vector file");
      endcase
    end
    $display("Testbench passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (n_vec != 0);
    repeat (n_vec * cycles_per_vec) @(posedge CLK2);
    abort_run("timeout, the vectors did not complete in time");
  end

endmodule

`default_nettype wire
